// ==== ntt_ctrl_pkg.sv ====
/*
 * Sizes and shared types for the NTT address and sequencing controller.
 * The polynomial is assumed to be 64 words of 4 coefficients in one memory.
 */
`default_nettype none

package ntt_ctrl_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    // Memory word address and twiddle ROM address widths
    localparam int MEM_ADDR_WIDTH     = 15;
    localparam int TWIDDLE_ADDR_WIDTH = 7;

    // Transform shape
    localparam int NTT_NUM_ROUNDS     = 4;
    localparam int NTT_WORDS          = 64;
    localparam int NTT_STRIDE         = 16;

    // Counter width for one pass over the polynomial
    localparam int NTT_WORD_CNT_WIDTH = $clog2(NTT_WORDS);

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // Forward transform is Cooley-Tukey, inverse is Gentleman-Sande
    typedef enum logic {
        ct = 1'b0,
        gs = 1'b1
    } ntt_mode_e;

    // Buffer bases, captured once per transform
    typedef struct packed {
        mem_addr_t src;
        mem_addr_t interim;
        mem_addr_t dest;
    } ntt_base_addr_t;

    // Mode and round of the transform in progress
    typedef struct packed {
        ntt_mode_e  mode;
        logic [1:0] round;
    } round_ctx_t;

endpackage

`default_nettype wire

// ==== ntt_round_seq.sv ====
/*
 * Round sequencer. The 64th write of a round always follows the last read,
 * so a round can only end in the draining state.
 */
`timescale 1ns/1ps
`default_nettype none

module ntt_round_seq
    import ntt_ctrl_pkg::*;
(
    input  wire            clk,
    input  wire            reset_n,
    input  wire            zeroize,
    input  wire            ntt_enable,
    input  wire ntt_mode_e      ntt_mode,
    input  wire ntt_base_addr_t ntt_mem_base_addr,
    input  wire            butterfly_ready,
    output round_ctx_t     round_ctx,
    output logic           round_start,
    output logic           rd_step,
    output logic           wr_step,
    output mem_addr_t      rd_base,
    output mem_addr_t      wr_base,
    output logic           busy,
    output logic           done
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_drain,
        st_done
    } seq_state_e;

    seq_state_e                    state;
    seq_state_e                    state_nxt;
    ntt_base_addr_t                base_q;
    ntt_mode_e                     mode_q;
    logic [1:0]                    round_q;
    logic [NTT_WORD_CNT_WIDTH-1:0] rd_cnt;
    logic [NTT_WORD_CNT_WIDTH:0]   wr_cnt;
    logic                          not_busy;
    logic                          start;
    logic                          last_wr;
    logic                          last_round;
    ntt_base_addr_t                base_sel;
    logic [1:0]                    round_sel;

    // Round 0 reads src, odd rounds read interim, round 2 reads dest
    function automatic mem_addr_t pick_rd_base(ntt_base_addr_t b, logic [1:0] r);
        mem_addr_t a;
        if (r == 2'd0)
            a = b.src;
        else if (r[0])
            a = b.interim;
        else
            a = b.dest;
        return a;
    endfunction

    // Even rounds write interim, odd rounds write dest
    function automatic mem_addr_t pick_wr_base(ntt_base_addr_t b, logic [1:0] r);
        mem_addr_t a;
        a = r[0] ? b.dest : b.interim;
        return a;
    endfunction

    // --------------------------------------------------
    // Strobes
    // --------------------------------------------------
    always_comb begin
        // The done cycle counts as idle, so a new start is taken there too
        not_busy    = (state == st_idle) || (state == st_done);
        start       = not_busy && ntt_enable;
        busy        = (state == st_read) || (state == st_drain);
        done        = (state == st_done);
        rd_step     = (state == st_read);
        // Writes stop counting once the round has all 64
        wr_step     = butterfly_ready && busy && (wr_cnt < NTT_WORDS);
        last_wr     = wr_step && (state == st_drain) && (wr_cnt == NTT_WORDS - 1);
        last_round  = (round_q == 2'(NTT_NUM_ROUNDS - 1));
        round_start = start || (last_wr && !last_round);
    end

    // --------------------------------------------------
    // Base selection
    // --------------------------------------------------
    // At round start the bases look one round ahead so the address
    // generators load the right value on that edge
    always_comb begin
        base_sel        = not_busy ? ntt_mem_base_addr : base_q;
        if (round_start)
            round_sel   = not_busy ? 2'd0 : round_q + 2'd1;
        else
            round_sel   = round_q;
        rd_base         = pick_rd_base(base_sel, round_sel);
        wr_base         = pick_wr_base(base_sel, round_sel);
        round_ctx.mode  = mode_q;
        round_ctx.round = round_q;
    end

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:  state_nxt = start ? st_read : st_idle;
            st_read:  state_nxt = (rd_cnt == NTT_WORD_CNT_WIDTH'(NTT_WORDS - 1)) ?
                                  st_drain : st_read;
            st_drain: begin
                if (last_wr)
                    state_nxt = last_round ? st_done : st_read;
            end
            st_done:  state_nxt = start ? st_read : st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= st_idle;
            mode_q  <= ct;
            round_q <= 2'd0;
            rd_cnt  <= '0;
            wr_cnt  <= '0;
        end else if (zeroize) begin
            state   <= st_idle;
            mode_q  <= ct;
            round_q <= 2'd0;
            rd_cnt  <= '0;
            wr_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (start)
                mode_q <= ntt_mode;
            // Round index restarts with the transform
            if (start)
                round_q <= 2'd0;
            else if (round_start)
                round_q <= round_q + 2'd1;
            // Per-round read and write counts
            if (round_start) begin
                rd_cnt <= '0;
                wr_cnt <= '0;
            end else begin
                if (rd_step)
                    rd_cnt <= rd_cnt + 1'b1;
                if (wr_step)
                    wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // Bases held for the whole transform
    always_ff @(posedge clk) begin
        if (start)
            base_q <= ntt_mem_base_addr;
    end

endmodule

`default_nettype wire

// ==== ntt_addr_gen.sv ====
/*
 * Memory address counter over one 64-word region starting at base.
 * Strided order visits columns 0, 16, 32, 48 and then moves one word on.
 */
`timescale 1ns/1ps
`default_nettype none

module ntt_addr_gen
    import ntt_ctrl_pkg::*;
(
    input  wire       clk,
    input  wire       reset_n,
    input  wire       zeroize,
    input  wire       round_start,
    input  wire       step,
    input  wire mem_addr_t base,
    input  wire       strided,
    output mem_addr_t addr
);

    logic [MEM_ADDR_WIDTH:0]   addr_sum;
    logic [MEM_ADDR_WIDTH:0]   addr_last;
    logic                      wrap;
    mem_addr_t                 addr_nxt;

    // --------------------------------------------------
    // Next address
    // --------------------------------------------------
    // One extra bit so the sum cannot overflow past the region end
    always_comb begin
        if (strided)
            addr_sum = {1'b0, addr} + (MEM_ADDR_WIDTH + 1)'(NTT_STRIDE);
        else
            addr_sum = {1'b0, addr} + 1'b1;
        addr_last = {1'b0, base} + (MEM_ADDR_WIDTH + 1)'(NTT_WORDS - 1);
        wrap      = (addr_sum > addr_last);

        // Strided wrap lands on the next column, e.g. base+48 to base+1
        if (!wrap)
            addr_nxt = addr_sum[MEM_ADDR_WIDTH-1:0];
        else if (strided)
            addr_nxt = MEM_ADDR_WIDTH'(addr_sum - (MEM_ADDR_WIDTH + 1)'(NTT_WORDS - 1));
        else
            addr_nxt = base;
    end

    // Address register, restart has priority over step
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            addr <= '0;
        else if (zeroize)
            addr <= '0;
        else if (round_start)
            addr <= base;
        else if (step)
            addr <= addr_nxt;
    end

endmodule

`default_nettype wire

// ==== ntt_twiddle_gen.sv ====
/*
 * Twiddle ROM addressing. bf_enable trails the read strobe by one cycle,
 * matching a single-cycle memory read latency.
 */
`timescale 1ns/1ps
`default_nettype none

module ntt_twiddle_gen
    import ntt_ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             reset_n,
    input  wire             zeroize,
    input  wire round_ctx_t round_ctx,
    input  wire             round_start,
    input  wire             rd_step,
    output logic            bf_enable,
    output logic [TWIDDLE_ADDR_WIDTH-1:0] twiddle_addr
);

    logic                          is_ct;
    logic [TWIDDLE_ADDR_WIDTH-1:0] idx;
    logic [TWIDDLE_ADDR_WIDTH-1:0] idx_end;
    logic [TWIDDLE_ADDR_WIDTH-1:0] idx_offset;

    // --------------------------------------------------
    // Per-round index range and ROM offset
    // --------------------------------------------------
    // ct grows the twiddle set each round, gs shrinks it
    always_comb begin
        is_ct = (round_ctx.mode == ct);
        case (round_ctx.round)
            2'd0: begin
                idx_end    = is_ct ? 'd0 : 'd63;
                idx_offset = 'd0;
            end
            2'd1: begin
                idx_end    = is_ct ? 'd3 : 'd15;
                idx_offset = is_ct ? 'd1 : 'd64;
            end
            2'd2: begin
                idx_end    = is_ct ? 'd15 : 'd3;
                idx_offset = is_ct ? 'd5 : 'd80;
            end
            default: begin
                idx_end    = is_ct ? 'd63 : 'd0;
                idx_offset = is_ct ? 'd21 : 'd84;
            end
        endcase
        twiddle_addr = idx + idx_offset;
    end

    // Butterfly enable, one cycle behind the read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            bf_enable <= 1'b0;
        else if (zeroize)
            bf_enable <= 1'b0;
        else
            bf_enable <= rd_step;
    end

    // Index wraps at the round's end value
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            idx <= '0;
        else if (zeroize)
            idx <= '0;
        else if (round_start)
            idx <= '0;
        else if (bf_enable)
            idx <= (idx == idx_end) ? '0 : idx + 1'b1;
    end

endmodule

`default_nettype wire

// ==== ntt_ctrl_top.sv ====
/*
 * NTT address and sequencing controller top. Reads never stall, and writes
 * follow butterfly_ready directly with no buffering.
 */
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_top
    import ntt_ctrl_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 zeroize,
    input  wire                 ntt_enable,
    input  wire ntt_mode_e      ntt_mode,
    input  wire ntt_base_addr_t ntt_mem_base_addr,
    input  wire                 butterfly_ready,
    output logic                mem_rd_en,
    output mem_addr_t           mem_rd_addr,
    output logic                mem_wr_en,
    output mem_addr_t           mem_wr_addr,
    output logic                bf_enable,
    output logic [TWIDDLE_ADDR_WIDTH-1:0] twiddle_addr,
    output logic                busy,
    output logic                done
);

    round_ctx_t round_ctx;
    logic       round_start;
    mem_addr_t  rd_base;
    mem_addr_t  wr_base;
    logic       rd_strided;
    logic       wr_strided;

    // ct reads strided and writes linear, gs does the opposite
    assign rd_strided = (round_ctx.mode == ct);
    assign wr_strided = (round_ctx.mode == gs);

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    ntt_round_seq u_seq (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .ntt_enable        (ntt_enable),
        .ntt_mode          (ntt_mode),
        .ntt_mem_base_addr (ntt_mem_base_addr),
        .butterfly_ready   (butterfly_ready),
        .round_ctx         (round_ctx),
        .round_start       (round_start),
        .rd_step           (mem_rd_en),
        .wr_step           (mem_wr_en),
        .rd_base           (rd_base),
        .wr_base           (wr_base),
        .busy              (busy),
        .done              (done)
    );

    // Read and write address counters
    ntt_addr_gen u_rd_addr (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .round_start (round_start),
        .step        (mem_rd_en),
        .base        (rd_base),
        .strided     (rd_strided),
        .addr        (mem_rd_addr)
    );

    ntt_addr_gen u_wr_addr (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .round_start (round_start),
        .step        (mem_wr_en),
        .base        (wr_base),
        .strided     (wr_strided),
        .addr        (mem_wr_addr)
    );

    // Twiddle ROM address and butterfly enable
    ntt_twiddle_gen u_twiddle (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .round_ctx    (round_ctx),
        .round_start  (round_start),
        .rd_step      (mem_rd_en),
        .bf_enable    (bf_enable),
        .twiddle_addr (twiddle_addr)
    );

endmodule

`default_nettype wire

// ==== ntt_ctrl_checker.sv ====
/*
 * Watches every controller port and predicts addresses, twiddles and completion.
 * Values are sampled on the rising edge. Inputs must change on the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_checker
    import ntt_ctrl_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 zeroize,
    input  wire                 ntt_enable,
    input  wire ntt_mode_e      ntt_mode,
    input  wire ntt_base_addr_t ntt_mem_base_addr,
    input  wire                 mem_rd_en,
    input  wire mem_addr_t      mem_rd_addr,
    input  wire                 mem_wr_en,
    input  wire mem_addr_t      mem_wr_addr,
    input  wire                 bf_enable,
    input  wire [TWIDDLE_ADDR_WIDTH-1:0] twiddle_addr,
    input  wire                 busy,
    input  wire                 done,
    input  wire                 test_end,
    input  int                  test_num,
    output int                  err_cnt
);

    logic           active;
    logic           done_due;
    ntt_mode_e      mode_q;
    ntt_base_addr_t base_q;
    int             round;
    int             rd_idx;
    int             wr_idx;
    int             bf_idx;
    int             err_mark;

    // --------------------------------------------------
    // Reference model of the address rules
    // --------------------------------------------------
    // Reads go src, interim, dest, interim and writes go interim, dest, interim, dest
    function automatic mem_addr_t round_base(ntt_base_addr_t b, int r, bit is_wr);
        mem_addr_t a;
        if (is_wr)
            a = (r % 2 == 0) ? b.interim : b.dest;
        else if (r == 0)
            a = b.src;
        else if (r == 2)
            a = b.dest;
        else
            a = b.interim;
        return a;
    endfunction

    // Offset of the i-th access, column-major over a 4x16 grid when strided
    function automatic int order_off(int i, bit strided);
        return strided ? (i % 4) * 16 + i / 4 : i;
    endfunction

    function automatic int tw_end(ntt_mode_e m, int r);
        int e;
        case (r)
            0:       e = (m == ct) ? 0 : 63;
            1:       e = (m == ct) ? 3 : 15;
            2:       e = (m == ct) ? 15 : 3;
            default: e = (m == ct) ? 63 : 0;
        endcase
        return e;
    endfunction

    function automatic int tw_off(ntt_mode_e m, int r);
        int o;
        case (r)
            0:       o = 0;
            1:       o = (m == ct) ? 1 : 64;
            2:       o = (m == ct) ? 5 : 80;
            default: o = (m == ct) ? 21 : 84;
        endcase
        return o;
    endfunction

    task automatic mismatch(string sig, logic [31:0] got, logic [31:0] exp);
        $display("FAILED %s got 0x%0h expected 0x%0h in round %0d", sig, got, exp, round);
        err_cnt++;
    endtask

    task automatic complain(string what);
        $display("Error in round %0d: %s", round, what);
        err_cnt++;
    endtask

    initial begin
        err_cnt  = 0;
        err_mark = 0;
        active   = 1'b0;
        done_due = 1'b0;
    end

    // --------------------------------------------------
    // Cycle-by-cycle comparison
    // --------------------------------------------------
    always @(posedge clk) begin
        mem_addr_t exp_addr;
        int        exp_tw;
        logic      rd_due;
        if (!reset_n || zeroize) begin
            active   = 1'b0;
            done_due = 1'b0;
        end else begin
            if (done !== done_due)
                mismatch("done", 32'(done), 32'(done_due));
            if (busy !== active)
                mismatch("busy", 32'(busy), 32'(active));
            done_due = 1'b0;
            if (!active) begin
                if (mem_rd_en || mem_wr_en || bf_enable)
                    complain("read, write or butterfly strobe while idle");
                if (ntt_enable) begin
                    active = 1'b1;
                    mode_q = ntt_mode;
                    base_q = ntt_mem_base_addr;
                    round  = 0;
                    rd_idx = 0;
                    wr_idx = 0;
                    bf_idx = 0;
                end
            end else begin
                // Reads run back to back from the cycle after a round begins
                rd_due = (rd_idx < NTT_WORDS);
                if (mem_rd_en !== rd_due)
                    mismatch("mem_rd_en", 32'(mem_rd_en), 32'(rd_due));
                if (mem_rd_en) begin
                    if (rd_due) begin
                        exp_addr = mem_addr_t'(int'(round_base(base_q, round, 1'b0)) +
                                   order_off(rd_idx, mode_q == ct));
                        if (mem_rd_addr !== exp_addr)
                            mismatch("mem_rd_addr", 32'(mem_rd_addr), 32'(exp_addr));
                    end
                    rd_idx++;
                end
                if (bf_enable) begin
                    exp_tw = tw_off(mode_q, round) + bf_idx % (tw_end(mode_q, round) + 1);
                    if (int'(twiddle_addr) != exp_tw)
                        mismatch("twiddle_addr", 32'(twiddle_addr), 32'(exp_tw));
                    bf_idx++;
                end
                if (mem_wr_en) begin
                    exp_addr = mem_addr_t'(int'(round_base(base_q, round, 1'b1)) +
                               order_off(wr_idx, mode_q == gs));
                    if (mem_wr_addr !== exp_addr)
                        mismatch("mem_wr_addr", 32'(mem_wr_addr), 32'(exp_addr));
                    wr_idx++;
                    // Last write of the round
                    if (wr_idx == NTT_WORDS) begin
                        if (rd_idx != NTT_WORDS || bf_idx != NTT_WORDS)
                            complain("round ended without exactly 64 reads and butterflies");
                        if (round == NTT_NUM_ROUNDS - 1) begin
                            active   = 1'b0;
                            done_due = 1'b1;
                        end else begin
                            round++;
                            rd_idx = 0;
                            wr_idx = 0;
                            bf_idx = 0;
                        end
                    end
                end
            end
        end
        // One summary line per test
        if (test_end) begin
            if (err_cnt == err_mark)
                $display("test %0d: all checks matched", test_num);
            else
                $display("test %0d: %0d mismatches", test_num, err_cnt - err_mark);
            err_mark = err_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== ntt_ctrl_assert.sv ====
/*
 * Concurrent checks bound into the controller top.
 * Address ranges use the base latched at each round start.
 */
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_assert
    import ntt_ctrl_pkg::*;
(
    input wire            clk,
    input wire            reset_n,
    input wire            done,
    input wire            busy,
    input wire            mem_rd_en,
    input wire            mem_wr_en,
    input wire            bf_enable,
    input wire            round_start,
    input wire mem_addr_t mem_rd_addr,
    input wire mem_addr_t mem_wr_addr,
    input wire mem_addr_t rd_base,
    input wire mem_addr_t wr_base
);

    mem_addr_t rd_base_q;
    mem_addr_t wr_base_q;

    // Bases of the round in progress
    always_ff @(posedge clk) begin
        if (round_start) begin
            rd_base_q <= rd_base;
            wr_base_q <= wr_base;
        end
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done) else $error("done longer than one cycle");

    done_not_busy: assert property (@(posedge clk) disable iff (!reset_n)
        !(done && busy)) else $error("done and busy together");

    rd_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd_en |-> (mem_rd_addr >= rd_base_q) &&
        ({1'b0, mem_rd_addr} <= {1'b0, rd_base_q} + 16'd63))
        else $error("read address outside region");

    wr_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        mem_wr_en |-> (mem_wr_addr >= wr_base_q) &&
        ({1'b0, mem_wr_addr} <= {1'b0, wr_base_q} + 16'd63))
        else $error("write address outside region");

    bf_after_read: assert property (@(posedge clk) disable iff (!reset_n)
        bf_enable |-> $past(mem_rd_en)) else $error("butterfly enable without read");

endmodule

bind ntt_ctrl_top ntt_ctrl_assert u_assert (
    .clk         (clk),
    .reset_n     (reset_n),
    .done        (done),
    .busy        (busy),
    .mem_rd_en   (mem_rd_en),
    .mem_wr_en   (mem_wr_en),
    .bf_enable   (bf_enable),
    .round_start (round_start),
    .mem_rd_addr (mem_rd_addr),
    .mem_wr_addr (mem_wr_addr),
    .rd_base     (rd_base),
    .wr_base     (wr_base)
);

`default_nettype wire

// ==== ntt_ctrl_tb.sv ====
/*
 * Testbench for the NTT controller. A random butterfly model paces the writes.
 * A zero zeroize cycle in the table means the row runs to done.
 */
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl_tb
    import ntt_ctrl_pkg::*;
;

    localparam int NUM_ROWS    = 5;
    localparam int RUN_TIMEOUT = 5000;

    typedef struct packed {
        ntt_mode_e mode;
        mem_addr_t src;
        mem_addr_t interim;
        mem_addr_t dest;
        int        gap;
        int        zero_at;
    } stim_row_t;

    logic           clk;
    logic           reset_n;
    logic           zeroize;
    logic           ntt_enable;
    ntt_mode_e      ntt_mode;
    ntt_base_addr_t ntt_mem_base_addr;
    logic           butterfly_ready = 1'b0;
    logic           mem_rd_en;
    mem_addr_t      mem_rd_addr;
    logic           mem_wr_en;
    mem_addr_t      mem_wr_addr;
    logic           bf_enable;
    logic [TWIDDLE_ADDR_WIDTH-1:0] twiddle_addr;
    logic           busy;
    logic           done;
    logic           test_end;
    int             test_num;
    int             mismatch_cnt;
    int             timeouts;
    int             gap;
    int             outstanding = 0;
    int             seed = 70;
    stim_row_t      stim[NUM_ROWS];

    ntt_ctrl_top dut (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .ntt_enable        (ntt_enable),
        .ntt_mode          (ntt_mode),
        .ntt_mem_base_addr (ntt_mem_base_addr),
        .butterfly_ready   (butterfly_ready),
        .mem_rd_en         (mem_rd_en),
        .mem_rd_addr       (mem_rd_addr),
        .mem_wr_en         (mem_wr_en),
        .mem_wr_addr       (mem_wr_addr),
        .bf_enable         (bf_enable),
        .twiddle_addr      (twiddle_addr),
        .busy              (busy),
        .done              (done)
    );

    ntt_ctrl_checker u_checker (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .ntt_enable        (ntt_enable),
        .ntt_mode          (ntt_mode),
        .ntt_mem_base_addr (ntt_mem_base_addr),
        .mem_rd_en         (mem_rd_en),
        .mem_rd_addr       (mem_rd_addr),
        .mem_wr_en         (mem_wr_en),
        .mem_wr_addr       (mem_wr_addr),
        .bf_enable         (bf_enable),
        .twiddle_addr      (twiddle_addr),
        .busy              (busy),
        .done              (done),
        .test_end          (test_end),
        .test_num          (test_num),
        .err_cnt           (mismatch_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Butterfly model
    // --------------------------------------------------
    // A result can come back from the cycle after its enable onward
    always @(negedge clk) begin
        if (!busy) begin
            outstanding     = 0;
            // Stray pulses while idle, which the controller must ignore
            butterfly_ready = ($random(seed) % 2) != 0;
        end else begin
            if (butterfly_ready && outstanding > 0)
                outstanding--;
            butterfly_ready = (outstanding > 0) &&
                              ((($random(seed)) & 32'h7fffffff) % 100 >= gap);
            if (bf_enable)
                outstanding++;
        end
    end

    // Start one row, poke a start while busy, then wait for done or zeroize
    task automatic run_row(stim_row_t row);
        int cyc;
        logic finished;
        gap               = row.gap;
        ntt_mode          = row.mode;
        ntt_mem_base_addr = {row.src, row.interim, row.dest};
        ntt_enable        = 1'b1;
        @(negedge clk);
        ntt_enable = 1'b0;
        cyc        = 0;
        finished   = 1'b0;
        while (!finished && cyc < RUN_TIMEOUT) begin
            @(negedge clk);
            cyc++;
            zeroize    = (row.zero_at != 0) && (cyc == row.zero_at);
            // A second start with the other mode must be ignored
            ntt_enable = (cyc == 30);
            ntt_mode   = (cyc == 30) ? ((row.mode == ct) ? gs : ct) : row.mode;
            if (done)
                finished = 1'b1;
            if (row.zero_at != 0 && cyc == row.zero_at + 20)
                finished = 1'b1;
        end
        ntt_enable = 1'b0;
        zeroize    = 1'b0;
        if (!finished) begin
            $display("test %0d timed out waiting for done", test_num);
            timeouts++;
            // Bring the controller back to idle for the next row
            zeroize = 1'b1;
            @(negedge clk);
            zeroize = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        reset_n           = 1'b0;
        zeroize           = 1'b0;
        ntt_enable        = 1'b0;
        ntt_mode          = ct;
        ntt_mem_base_addr = '0;
        test_end          = 1'b0;
        test_num          = 0;
        timeouts          = 0;
        gap               = 0;

        // mode, src, interim, dest, butterfly gap percent, zeroize cycle
        stim[0] = '{ct, 15'h0000, 15'h0100, 15'h0200, 0, 0};
        stim[1] = '{gs, 15'h1000, 15'h2040, 15'h7f00, 40, 0};
        stim[2] = '{ct, 15'h7fc0, 15'h0040, 15'h3000, 25, 0};
        stim[3] = '{gs, 15'h0400, 15'h0500, 15'h0600, 10, 150};
        stim[4] = '{ct, 15'h0a00, 15'h0b80, 15'h0c40, 60, 0};

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < NUM_ROWS; i++) begin
            test_num = i;
            run_row(stim[i]);
            @(negedge clk);
            test_end = 1'b1;
            @(negedge clk);
            test_end = 1'b0;
            @(negedge clk);
        end

        $display("tests %0d, mismatches %0d, timeouts %0d", NUM_ROWS, mismatch_cnt, timeouts);
        if (mismatch_cnt == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
ntt_ctrl_pkg.sv
ntt_round_seq.sv
ntt_addr_gen.sv
ntt_twiddle_gen.sv
ntt_ctrl_top.sv
ntt_ctrl_checker.sv
ntt_ctrl_assert.sv
ntt_ctrl_tb.sv

// ==== Makefile ====
TOP := ntt_ctrl_tb

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
